// File: rtl/soc_defs.svh
// SoC memory map and sizes
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// **************************************************
// Memory map
// **************************************************

`define SOC_RAM_BYTES 32'd4096 // Shared word RAM
`define SOC_IO_BASE `SOC_RAM_BYTES // Registers start right after RAM

// Register offsets from SOC_IO_BASE
`define SOC_REG_FETCH_ADDR 32'h000
`define SOC_REG_FETCH_COUNT 32'h004
`define SOC_REG_FETCH_START 32'h008 // Write 1 to start
`define SOC_REG_CLEAR_START 32'h00C // Write 1 to start
`define SOC_REG_CLEAR_COLOR 32'h010
`define SOC_REG_BUSY 32'h02C
`define SOC_REG_BTN_BASE 32'h200 // One word per button
`define SOC_REG_CTRL_BASE 32'h400 // One word per controller bit

// **************************************************
// Inputs
// **************************************************

`define SOC_DEBOUNCE_CYCLES 16 // Hold window after a press
`define SOC_BTN_COUNT 7
`define SOC_CTRL_COUNT 12

`endif

// File: rtl/soc_pkg.sv
// SoC bus and pixel types
package soc_pkg;

	// **************************************************
	// Wishbone classic
	// **************************************************

	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr; // Byte address
		logic [31:0] dat; // Write data
		logic [3:0] sel; // Byte lanes
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic ack; // One cycle per access
		logic [31:0] dat; // Read data
	} wb_rsp_t;

	// **************************************************
	// Pixel stream
	// **************************************************

	// One beat toward the display side, RGB565 colour
	typedef struct packed {
		logic [15:0] data;
		logic last; // Final pixel of a job
	} pixel_t;

endpackage

// File: rtl/bus_arbiter.sv
// RAM arbiter and register router
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_arbiter (
	input logic rst_n,
	input logic hdmi_pixClk,
	input soc_pkg::wb_req_t cpu_req,
	output soc_pkg::wb_rsp_t cpu_rsp,
	input soc_pkg::wb_req_t fetch_req,
	output soc_pkg::wb_rsp_t fetch_rsp,
	output soc_pkg::wb_req_t ram_req,
	input soc_pkg::wb_rsp_t ram_rsp,
	output soc_pkg::wb_req_t io_req,
	input soc_pkg::wb_rsp_t io_rsp
);
	import soc_pkg::*;

	logic cpu_io, cpu_ram, fetch_ram;
	logic gnt_cpu, gnt_fetch;
	logic lock_cpu_q, lock_fetch_q; // Grant held from last cycle
	logic last_cpu_q; // Processor was served last

	assign cpu_io = cpu_req.cyc && cpu_req.stb && (cpu_req.adr >= `SOC_IO_BASE);
	assign cpu_ram = cpu_req.cyc && cpu_req.stb && (cpu_req.adr < `SOC_RAM_BYTES);
	assign fetch_ram = fetch_req.cyc && fetch_req.stb;

	// Grant decided in the request cycle, locked while cyc stays high
	always_comb begin
		gnt_cpu = 1'b0;
		gnt_fetch = 1'b0;
		if (lock_cpu_q && cpu_req.cyc) begin
			gnt_cpu = 1'b1;
		end else if (lock_fetch_q && fetch_req.cyc) begin
			gnt_fetch = 1'b1;
		end else if (cpu_ram && fetch_ram) begin
			gnt_cpu = !last_cpu_q; // Round robin
			gnt_fetch = last_cpu_q;
		end else begin
			gnt_cpu = cpu_ram;
			gnt_fetch = fetch_ram;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			lock_cpu_q <= 1'b0;
			lock_fetch_q <= 1'b0;
			last_cpu_q <= 1'b0;
		end else begin
			lock_cpu_q <= gnt_cpu;
			lock_fetch_q <= gnt_fetch;
			if (gnt_cpu) begin
				last_cpu_q <= 1'b1;
			end else if (gnt_fetch) begin
				last_cpu_q <= 1'b0;
			end
		end
	end

	always_comb begin
		ram_req = '0;
		if (gnt_fetch) begin
			ram_req = fetch_req;
		end else if (gnt_cpu) begin
			ram_req = cpu_req;
			ram_req.stb = cpu_ram; // Register access while locked
		end
		io_req = cpu_req;
		io_req.cyc = cpu_io;
		io_req.stb = cpu_io;
	end

	// Ack only to the owner of the access
	assign cpu_rsp.ack = io_rsp.ack || (ram_rsp.ack && gnt_cpu);
	assign cpu_rsp.dat = io_rsp.ack ? io_rsp.dat : ram_rsp.dat;
	assign fetch_rsp.ack = ram_rsp.ack && gnt_fetch;
	assign fetch_rsp.dat = ram_rsp.dat;

endmodule

// File: rtl/shared_ram.sv
// Shared word RAM
`timescale 1ns/1ps
`include "soc_defs.svh"

module shared_ram (
	input logic hdmi_pixClk,
	input logic rst_n,
	input soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp
);
	import soc_pkg::*;

	localparam int WORDS = `SOC_RAM_BYTES / 4;
	localparam int AW = $clog2(WORDS);

	logic [31:0] mem [WORDS];
	logic [AW-1:0] widx;
	logic access;
	logic ack_q;
	logic [31:0] rdata_q;

	assign widx = req.adr[AW+1:2];
	assign access = req.cyc && req.stb && !ack_q; // First cycle of a request

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (access) begin
			if (req.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req.sel[b]) begin
						mem[widx][8*b +: 8] <= req.dat[8*b +: 8];
					end
				end
			end
			rdata_q <= mem[widx]; // Whole word
		end
	end

	assign rsp = '{ack: ack_q, dat: rdata_q};

endmodule

// File: rtl/btn_debounce.sv
// Push-button debouncer
`timescale 1ns/1ps
`include "soc_defs.svh"

module btn_debounce #(
	parameter int width = `SOC_BTN_COUNT
) (
	input logic hdmi_pixClk,
	input logic rst_n,
	input logic [width-1:0] btn,
	output logic [width-1:0] btn_stable
);

	localparam int TW = $clog2(`SOC_DEBOUNCE_CYCLES + 1);

	logic [TW-1:0] timer [width]; // Zero means idle

	// **************************************************
	// One hold timer per button
	// **************************************************

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			btn_stable <= '0;
			for (int i = 0; i < width; i++) begin
				timer[i] <= '0;
			end
		end else begin
			for (int i = 0; i < width; i++) begin
				if (timer[i] == '0) begin
					btn_stable[i] <= btn[i]; // Follow input while idle
					if (btn[i]) begin
						timer[i] <= TW'(`SOC_DEBOUNCE_CYCLES);
					end
				end else begin
					timer[i] <= timer[i] - 1'b1; // Output frozen
				end
			end
		end
	end

endmodule

// File: rtl/io_regs.sv
// Memory-mapped register block
`timescale 1ns/1ps
`include "soc_defs.svh"

module io_regs (
	input logic hdmi_pixClk,
	input logic rst_n,
	input soc_pkg::wb_req_t req,
	output soc_pkg::wb_rsp_t rsp,
	input logic [`SOC_BTN_COUNT-1:0] btn_stable,
	input logic [`SOC_CTRL_COUNT-1:0] controller_btns,
	input logic busy,
	output logic [31:0] fetch_addr,
	output logic [31:0] fetch_count,
	output logic [15:0] clear_color,
	output logic fetch_start,
	output logic clear_start
);
	import soc_pkg::*;

	localparam int BIW = $clog2(`SOC_BTN_COUNT);
	localparam int CIW = $clog2(`SOC_CTRL_COUNT);

	logic access, wr_full;
	logic ack_q;
	logic [31:0] rdata_q, rd_data;
	logic [31:0] off, btn_off, ctrl_off;
	logic hit_btn, hit_ctrl;
	logic [BIW-1:0] btn_idx;
	logic [CIW-1:0] ctrl_idx;

	assign access = req.cyc && req.stb && !ack_q;
	assign wr_full = access && req.we && (&req.sel); // Partial writes dropped

	// **************************************************
	// Address decode
	// **************************************************

	assign off = req.adr - `SOC_IO_BASE;
	assign btn_off = off - `SOC_REG_BTN_BASE;
	assign ctrl_off = off - `SOC_REG_CTRL_BASE;
	assign hit_btn = (btn_off < 4 * `SOC_BTN_COUNT) && (off[1:0] == 2'b00);
	assign hit_ctrl = (ctrl_off < 4 * `SOC_CTRL_COUNT) && (off[1:0] == 2'b00);
	assign btn_idx = btn_off[2 +: BIW];
	assign ctrl_idx = ctrl_off[2 +: CIW];

	always_comb begin
		rd_data = '0;
		if (hit_btn) begin
			rd_data = {31'b0, btn_stable[btn_idx]};
		end else if (hit_ctrl) begin
			rd_data = {31'b0, controller_btns[ctrl_idx]};
		end else begin
			case (off)
				`SOC_REG_FETCH_ADDR: rd_data = fetch_addr;
				`SOC_REG_FETCH_COUNT: rd_data = fetch_count;
				`SOC_REG_CLEAR_COLOR: rd_data = {16'b0, clear_color};
				`SOC_REG_BUSY: rd_data = {31'b0, busy};
				default: rd_data = '0; // Unmapped
			endcase
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
			rdata_q <= '0;
			fetch_addr <= '0;
			fetch_count <= '0;
			clear_color <= '0;
			fetch_start <= 1'b0;
			clear_start <= 1'b0;
		end else begin
			ack_q <= access; // Every access acked
			fetch_start <= 1'b0;
			clear_start <= 1'b0;
			if (access) begin
				rdata_q <= rd_data;
			end
			if (wr_full) begin
				case (off)
					`SOC_REG_FETCH_ADDR: fetch_addr <= req.dat;
					`SOC_REG_FETCH_COUNT: fetch_count <= req.dat;
					`SOC_REG_CLEAR_COLOR: clear_color <= req.dat[15:0];
					`SOC_REG_FETCH_START: fetch_start <= req.dat[0] && !busy;
					`SOC_REG_CLEAR_START: clear_start <= req.dat[0] && !busy;
					default: ;
				endcase
			end
		end
	end

	assign rsp = '{ack: ack_q, dat: rdata_q};

endmodule

// File: rtl/pixel_fetch.sv
// Pixel fetch engine
`timescale 1ns/1ps

module pixel_fetch (
	input logic hdmi_pixClk,
	input logic rst_n,
	input logic fetch_start,
	input logic clear_start,
	input logic [31:0] fetch_addr,
	input logic [31:0] fetch_count,
	input logic [15:0] clear_color,
	output logic busy,
	output soc_pkg::wb_req_t bus_req,
	input soc_pkg::wb_rsp_t bus_rsp,
	output soc_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready
);
	import soc_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_NEXT, ST_READ, ST_EMIT} state_t;

	state_t state_q;
	logic cyc_q;
	logic clear_q; // Clear job, no reads
	logic hi_pending_q; // High half of word still to send
	logic [31:0] remain_q; // Pixels left including current
	logic [31:0] addr_q;
	logic [15:0] hi_q;
	pixel_t pix_q;

	// **************************************************
	// Job FSM
	// **************************************************

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			busy <= 1'b0;
			cyc_q <= 1'b0;
			pix_valid <= 1'b0;
			clear_q <= 1'b0;
			hi_pending_q <= 1'b0;
			remain_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (fetch_start || clear_start) begin
						busy <= 1'b1;
						remain_q <= fetch_count;
						clear_q <= !fetch_start;
						state_q <= ST_NEXT;
					end
				end
				ST_NEXT: begin
					if (remain_q == '0) begin
						busy <= 1'b0; // Empty job
						state_q <= ST_IDLE;
					end else if (clear_q) begin
						pix_valid <= 1'b1;
						state_q <= ST_EMIT;
					end else begin
						cyc_q <= 1'b1;
						state_q <= ST_READ;
					end
				end
				ST_READ: begin
					if (bus_rsp.ack) begin
						cyc_q <= 1'b0;
						hi_pending_q <= 1'b1;
						pix_valid <= 1'b1;
						state_q <= ST_EMIT;
					end
				end
				ST_EMIT: begin
					if (pix_ready) begin
						remain_q <= remain_q - 1'b1;
						hi_pending_q <= 1'b0;
						if (remain_q == 32'd1) begin
							pix_valid <= 1'b0;
							busy <= 1'b0;
							state_q <= ST_IDLE;
						end else if (!clear_q && !hi_pending_q) begin
							pix_valid <= 1'b0; // Word used up, next read
							cyc_q <= 1'b1;
							state_q <= ST_READ;
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// **************************************************
	// Address and pixel data
	// **************************************************

	always_ff @(posedge hdmi_pixClk) begin
		case (state_q)
			ST_IDLE: addr_q <= {fetch_addr[31:2], 2'b00};
			ST_NEXT: pix_q <= '{data: clear_color, last: remain_q == 32'd1};
			ST_READ: begin
				if (bus_rsp.ack) begin
					addr_q <= addr_q + 32'd4;
					hi_q <= bus_rsp.dat[31:16];
					pix_q <= '{data: bus_rsp.dat[15:0], last: remain_q == 32'd1}; // Low half first
				end
			end
			ST_EMIT: begin
				if (pix_ready) begin
					if (!clear_q && hi_pending_q) begin
						pix_q.data <= hi_q;
					end
					pix_q.last <= remain_q == 32'd2;
				end
			end
			default: ;
		endcase
	end

	assign bus_req = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: addr_q, dat: 32'b0, sel: 4'hF};
	assign pix = pix_q;

endmodule

// File: rtl/gfx_soc_top.sv
// Graphics SoC memory and I/O top
`timescale 1ns/1ps
`include "soc_defs.svh"

module gfx_soc_top (
	input logic hdmi_pixClk,
	input logic rst_n,
	input soc_pkg::wb_req_t cpu_req,
	output soc_pkg::wb_rsp_t cpu_rsp,
	input logic [`SOC_BTN_COUNT-1:0] btn,
	input logic [`SOC_CTRL_COUNT-1:0] controller_btns,
	output soc_pkg::pixel_t pix,
	output logic pix_valid,
	input logic pix_ready
);
	import soc_pkg::*;

	wb_req_t fetch_req, ram_req, io_req;
	wb_rsp_t fetch_rsp, ram_rsp, io_rsp;
	logic [`SOC_BTN_COUNT-1:0] btn_stable;
	logic [31:0] fetch_addr, fetch_count;
	logic [15:0] clear_color;
	logic fetch_start, clear_start, busy;

	// **************************************************
	// Bus side
	// **************************************************

	bus_arbiter arb_i (
		.rst_n(rst_n), .hdmi_pixClk(hdmi_pixClk),
		.cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
		.fetch_req(fetch_req), .fetch_rsp(fetch_rsp),
		.ram_req(ram_req), .ram_rsp(ram_rsp),
		.io_req(io_req), .io_rsp(io_rsp)
	);

	shared_ram ram_i (.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n), .req(ram_req), .rsp(ram_rsp));

	io_regs regs_i (
		.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n), .req(io_req), .rsp(io_rsp),
		.btn_stable(btn_stable), .controller_btns(controller_btns), .busy(busy),
		.fetch_addr(fetch_addr), .fetch_count(fetch_count), .clear_color(clear_color),
		.fetch_start(fetch_start), .clear_start(clear_start)
	);

	btn_debounce #(.width(`SOC_BTN_COUNT)) deb_i (
		.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n), .btn(btn), .btn_stable(btn_stable)
	);

	// Second bus master, display stream out
	pixel_fetch fetch_i (
		.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n),
		.fetch_start(fetch_start), .clear_start(clear_start),
		.fetch_addr(fetch_addr), .fetch_count(fetch_count), .clear_color(clear_color),
		.busy(busy), .bus_req(fetch_req), .bus_rsp(fetch_rsp),
		.pix(pix), .pix_valid(pix_valid), .pix_ready(pix_ready)
	);

endmodule

// File: tests/gfx_soc_properties.sv
// Bus and pixel stream properties
`timescale 1ns/1ps

module gfx_soc_properties (
	input logic hdmi_pixClk,
	input logic rst_n,
	input soc_pkg::wb_req_t m0_req,
	input soc_pkg::wb_rsp_t m0_rsp,
	input soc_pkg::wb_req_t m1_req,
	input soc_pkg::wb_rsp_t m1_rsp,
	input logic gnt0,
	input logic gnt1,
	input soc_pkg::pixel_t pix,
	input logic pix_valid,
	input logic pix_ready
);
	import soc_pkg::*;

	// **************************************************
	// Wishbone handshakes
	// **************************************************

	m0_ack_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		m0_rsp.ack |=> !m0_rsp.ack) else $error("Master 0 ack held longer than one cycle");
	m1_ack_pulse: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		m1_rsp.ack |=> !m1_rsp.ack) else $error("Master 1 ack held longer than one cycle");

	// Request frozen until the slave answers
	m0_req_hold: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		m0_req.cyc && m0_req.stb && !m0_rsp.ack |=> $stable(m0_req))
		else $error("Master 0 request changed before ack");
	m1_req_hold: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		m1_req.cyc && m1_req.stb && !m1_rsp.ack |=> $stable(m1_req))
		else $error("Master 1 request changed before ack");

	one_grant: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		!(gnt0 && gnt1)) else $error("RAM granted to both masters at once");

	// Stalled beat keeps its data
	beat_hold: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix))
		else $error("Pixel beat changed while stalled");

endmodule

bind bus_arbiter gfx_soc_properties arb_props_i (
	.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n),
	.m0_req(cpu_req), .m0_rsp(cpu_rsp), .m1_req(fetch_req), .m1_rsp(fetch_rsp),
	.gnt0(gnt_cpu), .gnt1(gnt_fetch),
	.pix('0), .pix_valid(1'b0), .pix_ready(1'b1)
);

bind pixel_fetch gfx_soc_properties fetch_props_i (
	.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n),
	.m0_req(bus_req), .m0_rsp(bus_rsp), .m1_req(bus_req), .m1_rsp(bus_rsp),
	.gnt0(1'b0), .gnt1(1'b0),
	.pix(pix), .pix_valid(pix_valid), .pix_ready(pix_ready)
);

// File: tests/gfx_soc_tb.sv
// Graphics SoC testbench
`timescale 1ns/1ps
`include "soc_defs.svh"

module gfx_soc_tb;
	import soc_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int WORDS = `SOC_RAM_BYTES / 4;
	localparam int RAM_OPS = 150;
	localparam int JOBS = 6; // Fetch jobs and clear jobs each
	localparam int MAX_PIX = 48;
	localparam int INPUT_ROUNDS = 4;
	localparam int BUS_CYCLES = 8; // Worst access under contention
	localparam int BEAT_CYCLES = 16;
	localparam int WATCHDOG_CYCLES = 2 * (BUS_CYCLES * (WORDS + 3 * RAM_OPS + 200
		+ INPUT_ROUNDS * 20) + BEAT_CYCLES * MAX_PIX * (2 * JOBS + 1)
		+ INPUT_ROUNDS * `SOC_DEBOUNCE_CYCLES);

	logic hdmi_pixClk = 1'b0;
	logic rst_n;
	wb_req_t cpu_req;
	wb_rsp_t cpu_rsp;
	logic [`SOC_BTN_COUNT-1:0] btn;
	logic [`SOC_CTRL_COUNT-1:0] controller_btns;
	pixel_t pix;
	logic pix_valid;
	logic pix_ready = 1'b0;

	logic [31:0] model_ram [WORDS];
	pixel_t exp_pix [$]; // Beats still owed by the DUT
	string test_name = "reset";
	logic [31:0] val;
	logic [31:0] scratch;
	logic [31:0] reg_offs [3] = '{`SOC_REG_FETCH_ADDR, `SOC_REG_FETCH_COUNT, `SOC_REG_CLEAR_COLOR};
	logic [31:0] gap_offs [6] = '{32'h008, 32'h00C, 32'h014, 32'h21C, 32'h430, 32'h800};

	gfx_soc_top dut_i (.*);

	always #(CLK_PERIOD / 2) hdmi_pixClk = ~hdmi_pixClk;

	always @(posedge hdmi_pixClk) begin
		#1;
		pix_ready = ($urandom % 4) != 0; // Sink stalls about one cycle in four
	end

	// **************************************************
	// Checking and bus helpers
	// **************************************************

	task automatic stop_run();
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
			stop_run();
		end
	endtask

	// Called a little after a rising edge, returns at the same point
	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, output logic [31:0] rdat);
		cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
		@(negedge hdmi_pixClk);
		while (!cpu_rsp.ack) begin
			@(negedge hdmi_pixClk);
		end
		rdat = cpu_rsp.dat;
		@(posedge hdmi_pixClk);
		#1;
		cpu_req = '0;
		@(posedge hdmi_pixClk); // Idle cycle lets the other master in
		#1;
	endtask

	task automatic ram_write(input int idx, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] unused;
		bus_access(1'b1, 32'(idx) * 4, dat, sel, unused);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				model_ram[idx][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	task automatic ram_check(input int idx);
		logic [31:0] got;
		bus_access(1'b0, 32'(idx) * 4, 32'd0, 4'hF, got);
		check_value($sformatf("ram word %0d", idx), model_ram[idx], got);
	endtask

	task automatic ram_traffic(input int lo, input int span, input int ops);
		int idx;
		for (int n = 0; n < ops; n++) begin
			idx = lo + $urandom % span;
			ram_write(idx, $urandom, 4'($urandom));
			ram_check(idx);
			ram_check(lo + $urandom % span);
		end
	endtask

	task automatic write_reg(input logic [31:0] off, input logic [31:0] dat);
		logic [31:0] unused;
		bus_access(1'b1, `SOC_IO_BASE + off, dat, 4'hF, unused);
	endtask

	task automatic check_reg(input string what, input logic [31:0] off, input logic [31:0] exp);
		logic [31:0] got;
		bus_access(1'b0, `SOC_IO_BASE + off, 32'd0, 4'hF, got);
		check_value(what, exp, got);
	endtask

	// Low half first, then high half
	task automatic start_job(input bit clear, input logic [15:0] color, input int first_word,
			input int count);
		logic [31:0] word;
		pixel_t beat;
		write_reg(`SOC_REG_FETCH_ADDR, 32'(first_word) * 4);
		write_reg(`SOC_REG_FETCH_COUNT, count);
		write_reg(`SOC_REG_CLEAR_COLOR, {16'h0, color});
		for (int p = 0; p < count; p++) begin
			word = model_ram[first_word + p / 2];
			beat.data = clear ? color : (p % 2 == 1 ? word[31:16] : word[15:0]);
			beat.last = p == count - 1;
			exp_pix.push_back(beat);
		end
		write_reg(clear ? `SOC_REG_CLEAR_START : `SOC_REG_FETCH_START, 32'd1);
	endtask

	task automatic wait_idle();
		logic [31:0] busy;
		busy = 32'd1;
		while (busy[0]) begin
			bus_access(1'b0, `SOC_IO_BASE + `SOC_REG_BUSY, 32'd0, 4'hF, busy);
		end
		assert (exp_pix.size() == 0) else begin
			$display("Job in %s ended with %0d pixel beats not delivered", test_name,
				exp_pix.size());
			stop_run();
		end
	endtask

	// Returns a little after the edge that ends the last expected beat
	task automatic wait_drained();
		while (exp_pix.size() != 0) begin
			@(posedge hdmi_pixClk);
			#1;
		end
	endtask

	always @(negedge hdmi_pixClk) begin
		if (rst_n && pix_valid && pix_ready) begin
			assert (exp_pix.size() > 0) else begin
				$display("Pixel beat in %s arrived with no job expecting it", test_name);
				stop_run();
			end
			check_value("pixel beat", 32'(exp_pix[0]), 32'(pix));
			void'(exp_pix.pop_front());
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired in %s, the DUT stopped responding", test_name);
		stop_run();
	end

	// **************************************************
	// Test sequence
	// **************************************************

	initial begin
		void'($urandom(32'h5649));
		rst_n = 1'b0;
		cpu_req = '0;
		btn = '0;
		controller_btns = '0;
		repeat (5) @(posedge hdmi_pixClk);
		#1;
		rst_n = 1'b1;
		check_value("idle outputs", 32'd0, {30'd0, pix_valid, cpu_rsp.ack});

		test_name = "ram_bytes";
		for (int i = 0; i < WORDS; i++) begin
			ram_write(i, 32'(i + 1) * 32'h9E37_79B1 ^ 32'h5A5A_0F0F, 4'hF);
		end
		ram_traffic(0, WORDS, RAM_OPS);

		test_name = "registers";
		foreach (reg_offs[i]) begin
			val = $urandom;
			write_reg(reg_offs[i], val);
			bus_access(1'b1, `SOC_IO_BASE + reg_offs[i], ~val, 4'($urandom % 15), scratch);
			check_reg($sformatf("register %h", reg_offs[i]), reg_offs[i],
				(i == 2) ? {16'h0, val[15:0]} : val); // Partial write left it alone
		end
		foreach (gap_offs[i]) begin
			check_reg($sformatf("unmapped %h", gap_offs[i]), gap_offs[i], 32'd0);
		end

		test_name = "fetch_job";
		for (int j = 0; j < JOBS; j++) begin
			start_job(1'b0, 16'h0, $urandom % (WORDS - MAX_PIX),
				1 + 2 * ($urandom % (MAX_PIX / 2)) + j % 2);
			wait_idle();
		end

		test_name = "clear_job";
		for (int j = 0; j < JOBS; j++) begin
			val = $urandom;
			start_job(1'b1, val[15:0], 0, 24 + $urandom % (MAX_PIX - 23));
			check_reg("busy in job", `SOC_REG_BUSY, 32'd1);
			write_reg(`SOC_REG_FETCH_START, 32'd1); // Both ignored while busy
			write_reg(`SOC_REG_CLEAR_START, 32'd1);
			wait_drained();
			check_reg("busy after job", `SOC_REG_BUSY, 32'd0);
		end
		start_job(1'b1, 16'hFFFF, 0, 0);
		wait_idle();

		test_name = "shared_traffic";
		start_job(1'b0, 16'h0, $urandom % (WORDS / 2 - MAX_PIX), MAX_PIX);
		ram_traffic(WORDS / 2, WORDS / 2, 12);
		wait_idle();

		test_name = "inputs";
		repeat (INPUT_ROUNDS) begin
			val = $urandom;
			btn = val[`SOC_BTN_COUNT-1:0];
			controller_btns = val[31 -: `SOC_CTRL_COUNT];
			repeat (`SOC_DEBOUNCE_CYCLES + 4) @(posedge hdmi_pixClk);
			#1;
			for (int i = 0; i < `SOC_BTN_COUNT; i++) begin
				check_reg($sformatf("button %0d", i), `SOC_REG_BTN_BASE + 4 * i, {31'b0, btn[i]});
			end
			for (int i = 0; i < `SOC_CTRL_COUNT; i++) begin
				check_reg($sformatf("controller bit %0d", i), `SOC_REG_CTRL_BASE + 4 * i,
					{31'b0, controller_btns[i]});
			end
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/shared_ram.sv
rtl/btn_debounce.sv
rtl/io_regs.sv
rtl/pixel_fetch.sv
rtl/gfx_soc_top.sv
tests/gfx_soc_properties.sv
tests/gfx_soc_tb.sv

// File: Makefile
# Verilator build and run of the graphics SoC testbench
SIM      := verilator
TOP      := gfx_soc_tb
FILELIST := src.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation FAILED, no result in $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
